/* include/pool_defs.svh */
`ifndef POOL_DEFS_SVH
`define POOL_DEFS_SVH

// lane count and its log, keep the two in step
`define N_PE            4
`define LOG_N_PE        2

// depth of one bank is 2**ADDR_RAM pixels
`define ADDR_RAM        10

// running maxima held per lane
`define MAX_OUT_WID     16

`define LAT_READ_BUF    1   // feature bank read
`define LAT_POOL        1   // lane result register

`define PIX_W           8

`endif

/* design/pool_cfg_pkg.sv */
`default_nettype none

package pool_cfg_pkg;

    typedef logic [15:0] dim_t;     // width, height or size in pixels
    typedef logic [3:0]  win_t;     // pooling window side
    typedef logic [7:0]  chan_t;    // channel count or block index

    typedef enum logic [1:0] {
        idle,
        block_sel,
        block_run
    } pool_state_t;

endpackage

`default_nettype wire

/* design/pool_data_pkg.sv */
`default_nettype none

`include "pool_defs.svh"

package pool_data_pkg;

    typedef logic signed [`PIX_W-1:0]          pixel_t;
    typedef logic [`ADDR_RAM-1:0]              addr_t;
    typedef logic [`N_PE-1:0]                  lane_mask_t;     // one bit per lane
    typedef logic [$clog2(`MAX_OUT_WID)-1:0]   col_t;

endpackage

`default_nettype wire

/* design/pool_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pool_defs.svh"

module pool_ctrl (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,
    input  pool_cfg_pkg::chan_t         data_ch,
    input  pool_cfg_pkg::dim_t          data_wid,
    input  pool_cfg_pkg::dim_t          data_hei,
    input  pool_cfg_pkg::win_t          pool_horiz,
    input  pool_cfg_pkg::win_t          pool_vert,
    output pool_cfg_pkg::dim_t          out_wid,
    output pool_cfg_pkg::dim_t          out_hei,
    output pool_data_pkg::lane_mask_t   rd_en,
    output pool_data_pkg::addr_t        rd_addr,
    output pool_data_pkg::lane_mask_t   shift,
    output logic                        win_first,
    output logic                        win_last,
    output pool_data_pkg::col_t         out_col,
    output pool_data_pkg::lane_mask_t   wr_en,
    output pool_data_pkg::addr_t        wr_addr,
    output logic                        done
);

    pool_cfg_pkg::pool_state_t  state;

    pool_cfg_pkg::dim_t         input_size;
    pool_cfg_pkg::dim_t         output_size;
    pool_cfg_pkg::chan_t        blk_full;       // blocks with all lanes busy
    logic [`LOG_N_PE-1:0]       extra_c;
    pool_cfg_pkg::chan_t        blk_total;
    pool_cfg_pkg::chan_t        cb;
    pool_data_pkg::lane_mask_t  blk_mask;
    pool_data_pkg::lane_mask_t  part_mask;

    pool_cfg_pkg::dim_t         rd_idx;
    pool_cfg_pkg::dim_t         wr_idx;

    pool_data_pkg::lane_mask_t  sh_pipe [`LAT_READ_BUF];
    logic [`LAT_POOL-1:0]       wl_pipe;

    pool_cfg_pkg::win_t         h_cnt;
    pool_cfg_pkg::win_t         v_cnt;
    pool_cfg_pkg::win_t         h_last;
    pool_cfg_pkg::win_t         v_last;
    pool_cfg_pkg::dim_t         col_num;
    pool_data_pkg::col_t        oc;

    assign input_size  = data_wid * data_hei;
    assign out_wid     = data_wid / pool_cfg_pkg::dim_t'(pool_horiz);
    assign out_hei     = data_hei / pool_cfg_pkg::dim_t'(pool_vert);
    assign output_size = out_wid * out_hei;

    assign blk_full  = data_ch >> `LOG_N_PE;
    assign extra_c   = data_ch[`LOG_N_PE-1:0];
    assign blk_total = blk_full + pool_cfg_pkg::chan_t'(extra_c != '0);

    // low lanes only in the leftover block
    always_comb begin
        for (int i = 0; i < `N_PE; i++) begin
            part_mask[i] = (i < int'(extra_c));
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= pool_cfg_pkg::idle;
            cb       <= '0;
            blk_mask <= '0;
            rd_idx   <= '0;
            wr_idx   <= '0;
        end else begin
            case (state)
                pool_cfg_pkg::idle: begin
                    cb <= '0;
                    if (start) begin
                        state <= pool_cfg_pkg::block_sel;
                    end
                end
                pool_cfg_pkg::block_sel: begin
                    rd_idx <= '0;
                    wr_idx <= '0;
                    if (cb == blk_total) begin
                        state <= pool_cfg_pkg::idle;
                    end else begin
                        state    <= pool_cfg_pkg::block_run;
                        blk_mask <= (extra_c != '0 && cb == blk_full) ? part_mask : '1;
                    end
                end
                pool_cfg_pkg::block_run: begin
                    if (rd_idx < input_size) begin
                        rd_idx <= rd_idx + 1'b1;
                    end
                    if (wr_en != '0) begin
                        wr_idx <= wr_idx + 1'b1;
                    end
                    if (wr_idx == output_size) begin    // block drained
                        cb    <= cb + 1'b1;
                        state <= pool_cfg_pkg::block_sel;
                    end
                end
                default: begin
                    state <= pool_cfg_pkg::idle;
                end
            endcase
        end
    end

    assign done = (state == pool_cfg_pkg::block_sel) && (cb == blk_total);

    assign rd_en   = (state == pool_cfg_pkg::block_run && rd_idx < input_size) ? blk_mask : '0;
    assign rd_addr = pool_data_pkg::addr_t'(input_size * pool_cfg_pkg::dim_t'(cb) + rd_idx);
    assign wr_addr = pool_data_pkg::addr_t'(output_size * pool_cfg_pkg::dim_t'(cb) + wr_idx);

    // shift trails the bank read, write trails the closing shift
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `LAT_READ_BUF; i++) begin
                sh_pipe[i] <= '0;
            end
            wl_pipe <= '0;
        end else begin
            sh_pipe[0] <= rd_en;
            for (int i = 1; i < `LAT_READ_BUF; i++) begin
                sh_pipe[i] <= sh_pipe[i-1];
            end
            wl_pipe[0] <= win_last && (shift != '0);
            for (int i = 1; i < `LAT_POOL; i++) begin
                wl_pipe[i] <= wl_pipe[i-1];
            end
        end
    end

    assign shift = sh_pipe[`LAT_READ_BUF-1];
    assign wr_en = wl_pipe[`LAT_POOL-1] ? blk_mask : '0;

    assign h_last    = pool_horiz - 1'b1;
    assign v_last    = pool_vert - 1'b1;
    assign win_first = (h_cnt == '0) && (v_cnt == '0);
    assign win_last  = (h_cnt == h_last) && (v_cnt == v_last);
    assign out_col   = oc;

    // window position, one step per shifted pixel
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h_cnt   <= '0;
            v_cnt   <= '0;
            col_num <= '0;
            oc      <= '0;
        end else if (state != pool_cfg_pkg::block_run) begin
            h_cnt   <= '0;
            v_cnt   <= '0;
            col_num <= '0;
            oc      <= '0;
        end else if (shift != '0) begin
            if (h_cnt == h_last) begin
                h_cnt <= '0;
                oc    <= oc + 1'b1;
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
            if (col_num == data_wid - 1'b1) begin  // row wrap
                col_num <= '0;
                oc      <= '0;
                v_cnt   <= (v_cnt == v_last) ? '0 : v_cnt + 1'b1;
            end else begin
                col_num <= col_num + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* design/feature_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pool_defs.svh"

module feature_buffer (
    input  logic                        clk,
    input  logic                        load_en,
    input  logic [`LOG_N_PE-1:0]        load_bank,
    input  pool_data_pkg::addr_t        load_addr,
    input  pool_data_pkg::pixel_t       load_data,
    input  pool_data_pkg::lane_mask_t   rd_en,
    input  pool_data_pkg::addr_t        rd_addr,
    output pool_data_pkg::pixel_t       rd_data [`N_PE]
);

    // bank i holds channel cb*N_PE+i at base input_size*cb
    for (genvar i = 0; i < `N_PE; i++) begin : g_bank
        pool_data_pkg::pixel_t mem [2**`ADDR_RAM];

        always_ff @(posedge clk) begin
            if (load_en && int'(load_bank) == i) begin
                mem[load_addr] <= load_data;
            end
            if (rd_en[i]) begin
                rd_data[i] <= mem[rd_addr];   // shared address, per-bank enable
            end
        end
    end

endmodule

`default_nettype wire

/* design/pool_lane.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pool_defs.svh"

module pool_lane (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    shift,
    input  logic                    win_first,
    input  logic                    win_last,
    input  pool_data_pkg::col_t     out_col,
    input  pool_data_pkg::pixel_t   pixel,
    output pool_data_pkg::pixel_t   result
);

    // one partial max per output column of the current window row
    pool_data_pkg::pixel_t acc [`MAX_OUT_WID];
    pool_data_pkg::pixel_t prev;
    pool_data_pkg::pixel_t cur;

    assign prev = acc[out_col];

    // first pixel of a window restarts the entry
    assign cur = (win_first || pixel > prev) ? pixel : prev;   // signed compare

    always_ff @(posedge clk) begin
        if (shift) begin
            acc[out_col] <= cur;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result <= '0;
        end else if (shift && win_last) begin
            result <= cur;
        end
    end

endmodule

`default_nettype wire

/* design/result_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pool_defs.svh"

module result_buffer (
    input  logic                        clk,
    input  pool_data_pkg::lane_mask_t   wr_en,
    input  pool_data_pkg::addr_t        wr_addr,
    input  pool_data_pkg::pixel_t       wr_data [`N_PE],
    input  logic                        res_rd_en,
    input  logic [`LOG_N_PE-1:0]        res_rd_bank,
    input  pool_data_pkg::addr_t        res_rd_addr,
    output pool_data_pkg::pixel_t       res_rd_data
);

    pool_data_pkg::pixel_t  bank_q [`N_PE];
    logic [`LOG_N_PE-1:0]   sel_q;

    for (genvar i = 0; i < `N_PE; i++) begin : g_bank
        pool_data_pkg::pixel_t mem [2**`ADDR_RAM];

        always_ff @(posedge clk) begin
            if (wr_en[i]) begin
                mem[wr_addr] <= wr_data[i];
            end
            if (res_rd_en && int'(res_rd_bank) == i) begin
                bank_q[i] <= mem[res_rd_addr];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (res_rd_en) begin
            sel_q <= res_rd_bank;
        end
    end

    assign res_rd_data = bank_q[sel_q];    // bank mux after the registers

endmodule

`default_nettype wire

/* design/pool_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pool_defs.svh"

module pool_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  pool_cfg_pkg::chan_t     data_ch,
    input  pool_cfg_pkg::dim_t      data_wid,
    input  pool_cfg_pkg::dim_t      data_hei,
    input  pool_cfg_pkg::win_t      pool_horiz,
    input  pool_cfg_pkg::win_t      pool_vert,
    output pool_cfg_pkg::dim_t      out_wid,
    output pool_cfg_pkg::dim_t      out_hei,
    output logic                    done,
    input  logic                    load_en,
    input  logic [`LOG_N_PE-1:0]    load_bank,
    input  pool_data_pkg::addr_t    load_addr,
    input  pool_data_pkg::pixel_t   load_data,
    input  logic                    res_rd_en,
    input  logic [`LOG_N_PE-1:0]    res_rd_bank,
    input  pool_data_pkg::addr_t    res_rd_addr,
    output pool_data_pkg::pixel_t   res_rd_data
);

    pool_data_pkg::lane_mask_t  rd_en;
    pool_data_pkg::addr_t       rd_addr;
    pool_data_pkg::pixel_t      rd_data [`N_PE];
    pool_data_pkg::lane_mask_t  shift;
    logic                       win_first;
    logic                       win_last;
    pool_data_pkg::col_t        out_col;
    pool_data_pkg::lane_mask_t  wr_en;
    pool_data_pkg::addr_t       wr_addr;
    pool_data_pkg::pixel_t      result [`N_PE];

    pool_ctrl u_ctrl (
        .clk, .rst, .start, .data_ch, .data_wid, .data_hei, .pool_horiz, .pool_vert,
        .out_wid, .out_hei, .rd_en, .rd_addr, .shift, .win_first, .win_last,
        .out_col, .wr_en, .wr_addr, .done
    );

    feature_buffer u_fbuf (
        .clk, .load_en, .load_bank, .load_addr, .load_data, .rd_en, .rd_addr, .rd_data
    );

    // lane i pools bank i
    for (genvar i = 0; i < `N_PE; i++) begin : g_lane
        pool_lane u_lane (
            .clk, .rst, .shift(shift[i]), .win_first, .win_last, .out_col,
            .pixel(rd_data[i]), .result(result[i])
        );
    end

    result_buffer u_rbuf (
        .clk, .wr_en, .wr_addr, .wr_data(result),
        .res_rd_en, .res_rd_bank, .res_rd_addr, .res_rd_data
    );

endmodule

`default_nettype wire

/* tb/pool_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module pool_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;     // 100 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

/* tb/pool_props.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pool_defs.svh"

module pool_props (
    input logic                         clk,
    input logic                         rst,
    input pool_cfg_pkg::pool_state_t    state,
    input pool_cfg_pkg::chan_t          data_ch,
    input pool_cfg_pkg::chan_t          cb,
    input pool_data_pkg::lane_mask_t    rd_en,
    input pool_data_pkg::lane_mask_t    shift,
    input pool_data_pkg::lane_mask_t    wr_en,
    input logic                         done
);

    int fail_cnt = 0;   // summed into the testbench error count

    pool_data_pkg::lane_mask_t  live_mask;  // lanes owning a channel in block cb

    always_comb begin
        for (int i = 0; i < `N_PE; i++) begin
            live_mask[i] = (int'(cb) * `N_PE + i) < int'(data_ch);
        end
    end

    done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            $error("done held high for more than one cycle");
            fail_cnt++;
        end

    idle_no_write: assert property (@(posedge clk) disable iff (rst)
        state == pool_cfg_pkg::idle |-> wr_en == '0)
        else begin
            $error("result write while the controller is idle");
            fail_cnt++;
        end

    shift_follows_read: assert property (@(posedge clk) disable iff (rst)
        shift == $past(rd_en))
        else begin
            $error("shift does not trail rd_en by one cycle");
            fail_cnt++;
        end

    read_in_mask: assert property (@(posedge clk) disable iff (rst)
        (rd_en & ~live_mask) == '0)
        else begin
            $error("read on a lane with no channel in the current block");
            fail_cnt++;
        end

endmodule

`default_nettype wire

/* tb/pool_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pool_defs.svh"

module pool_tb;

    // input_size x block count of every run
    localparam int RUN_CYCLES = 64 + 2 * 64 + 2 * 64 + 32 + 32 + 2 * 64 + 64;
    // one cycle per loaded pixel, two per readback
    localparam int IO_CYCLES  = (4 + 16 + 4 + 8) * 64 + 2 * 4 * (16 + 64 + 16 + 8 + 32);
    localparam int WATCHDOG   = 2 * (RUN_CYCLES + IO_CYCLES) + 500;

    logic                       clk;
    logic                       rst;
    logic                       start;
    pool_cfg_pkg::chan_t        data_ch;
    pool_cfg_pkg::dim_t         data_wid;
    pool_cfg_pkg::dim_t         data_hei;
    pool_cfg_pkg::win_t         pool_horiz;
    pool_cfg_pkg::win_t         pool_vert;
    pool_cfg_pkg::dim_t         out_wid;
    pool_cfg_pkg::dim_t         out_hei;
    logic                       done;
    logic                       load_en;
    logic [`LOG_N_PE-1:0]       load_bank;
    pool_data_pkg::addr_t       load_addr;
    pool_data_pkg::pixel_t      load_data;
    logic                       res_rd_en;
    logic [`LOG_N_PE-1:0]       res_rd_bank;
    pool_data_pkg::addr_t       res_rd_addr;
    pool_data_pkg::pixel_t      res_rd_data;

    pool_data_pkg::pixel_t      img [`N_PE][2**`ADDR_RAM];      // feature buffer image
    pool_data_pkg::pixel_t      exp_res [`N_PE][2**`ADDR_RAM];  // expected result buffer
    integer                     seed = 79628;
    int                         done_cnt = 0;
    int                         n_tests = 0;
    int                         n_checks = 0;
    int                         n_err = 0;
    int                         test_err = 0;
    int                         asrt_fails = 0;

    pool_clk_gen u_clk (.clk(clk), .rst(rst));

    pool_top dut (
        .clk, .rst, .start, .data_ch, .data_wid, .data_hei, .pool_horiz, .pool_vert,
        .out_wid, .out_hei, .done, .load_en, .load_bank, .load_addr, .load_data,
        .res_rd_en, .res_rd_bank, .res_rd_addr, .res_rd_data
    );

    bind pool_ctrl pool_props u_props (
        .clk(clk), .rst(rst), .state(state), .data_ch(data_ch), .cb(cb),
        .rd_en(rd_en), .shift(shift), .wr_en(wr_en), .done(done)
    );

    always @(posedge clk) begin
        if (!rst && done) begin
            done_cnt <= done_cnt + 1;
        end
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("watchdog: no final done within %0d cycles, run aborted", WATCHDOG);
        $display("*** TEST FAILED ***");
        $finish;
    end

    task automatic check_val(input string name, input int expected, input int actual);
        n_checks++;
        if (expected != actual) begin
            n_err++;
            $display("** Error [%s]: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic begin_test();
        test_err = n_err;
        n_tests++;
    endtask

    task automatic end_test(input string name);
        if (n_err == test_err) begin
            $display("test %-14s ok", name);
        end else begin
            $display("test %-14s failed with %0d errors", name, n_err - test_err);
        end
    endtask

    // channel c sits in bank c % N_PE at input_size * (c / N_PE)
    task automatic load_image(input int nch, input int isz, input bit neg_ch0);
        pool_data_pkg::pixel_t px;
        int b;
        int a;
        for (int c = 0; c < nch; c++) begin
            for (int p = 0; p < isz; p++) begin
                px = pool_data_pkg::pixel_t'($random(seed));
                if (neg_ch0 && c == 0) begin
                    px[`PIX_W-1] = 1'b1;    // all negative
                end
                b = c % `N_PE;
                a = isz * (c / `N_PE) + p;
                img[b][a] = px;
                @(posedge clk);
                load_en   <= 1'b1;
                load_bank <= b[`LOG_N_PE-1:0];
                load_addr <= a[`ADDR_RAM-1:0];
                load_data <= px;
            end
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    // reference max pooling over non-overlapping windows
    task automatic compute_expected(input int nch, input int wid, input int hei,
                                    input int ph, input int pv);
        int ow;
        int oh;
        int b;
        int cb;
        int m;
        int px;
        ow = wid / ph;
        oh = hei / pv;
        for (int c = 0; c < nch; c++) begin
            b  = c % `N_PE;
            cb = c / `N_PE;
            for (int orow = 0; orow < oh; orow++) begin
                for (int ocol = 0; ocol < ow; ocol++) begin
                    m = -(2 ** (`PIX_W - 1));
                    for (int r = 0; r < pv; r++) begin
                        for (int k = 0; k < ph; k++) begin
                            px = img[b][wid * hei * cb + (orow * pv + r) * wid + ocol * ph + k];
                            m  = (px > m) ? px : m;
                        end
                    end
                    exp_res[b][ow * oh * cb + orow * ow + ocol] = pool_data_pkg::pixel_t'(m);
                end
            end
        end
    endtask

    // returns at the falling edge inside the done cycle
    task automatic run_pool(input int ch, input int wid, input int hei, input int ph, input int pv);
        @(posedge clk);
        start      <= 1'b1;
        data_ch    <= pool_cfg_pkg::chan_t'(ch);
        data_wid   <= pool_cfg_pkg::dim_t'(wid);
        data_hei   <= pool_cfg_pkg::dim_t'(hei);
        pool_horiz <= pool_cfg_pkg::win_t'(ph);
        pool_vert  <= pool_cfg_pkg::win_t'(pv);
        @(posedge clk);
        start <= 1'b0;
        do @(negedge clk); while (!done);
    endtask

    task automatic read_result(input int b, input int a, output pool_data_pkg::pixel_t v);
        @(posedge clk);
        res_rd_en   <= 1'b1;
        res_rd_bank <= b[`LOG_N_PE-1:0];
        res_rd_addr <= a[`ADDR_RAM-1:0];
        @(posedge clk);
        res_rd_en <= 1'b0;
        @(negedge clk);
        v = res_rd_data;
    endtask

    task automatic check_results(input string name, input int depth);
        pool_data_pkg::pixel_t v;
        for (int b = 0; b < `N_PE; b++) begin
            for (int a = 0; a < depth; a++) begin
                read_result(b, a, v);
                check_val(name, exp_res[b][a], v);
            end
        end
    endtask

    task automatic test_reset_state();
        begin_test();
        @(posedge clk);
        data_ch    <= 8'd4;
        data_wid   <= 16'd8;
        data_hei   <= 16'd8;
        pool_horiz <= 4'd2;
        pool_vert  <= 4'd2;
        repeat (2) @(negedge clk);
        check_val("reset_state", 0, done_cnt);
        check_val("reset_state", 0, done);
        check_val("reset_state", 4, out_wid);
        check_val("reset_state", 4, out_hei);
        end_test("reset_state");
    endtask

    task automatic test_single_block();
        int c0;
        begin_test();
        load_image(4, 64, 1'b1);
        compute_expected(4, 8, 8, 2, 2);
        c0 = done_cnt;
        run_pool(4, 8, 8, 2, 2);
        repeat (3) @(posedge clk);
        check_val("single_block", 1, done_cnt - c0);
        check_results("single_block", 16);
        end_test("single_block");
    endtask

    // six channels leave lanes 2..3 idle in block 1
    task automatic test_extra_block();
        int c0;
        begin_test();
        load_image(8, 64, 1'b0);
        compute_expected(8, 8, 8, 2, 2);
        c0 = done_cnt;
        run_pool(8, 8, 8, 2, 2);
        check_results("extra_block", 32);
        load_image(8, 64, 1'b0);
        compute_expected(6, 8, 8, 2, 2);
        run_pool(6, 8, 8, 2, 2);
        repeat (3) @(posedge clk);
        check_val("extra_block", 2, done_cnt - c0);
        check_results("extra_block", 32);
        end_test("extra_block");
    endtask

    task automatic test_rect_windows();
        begin_test();
        load_image(4, 32, 1'b0);
        compute_expected(4, 8, 4, 2, 1);
        run_pool(4, 8, 4, 2, 1);
        check_results("rect_2x1", 16);
        load_image(4, 32, 1'b0);
        compute_expected(4, 4, 8, 1, 4);
        run_pool(4, 4, 8, 1, 4);
        check_val("rect_1x4", 4, out_wid);     // 4 / 1
        check_val("rect_1x4", 2, out_hei);     // 8 / 4
        check_results("rect_1x4", 8);
        end_test("rect_windows");
    endtask

    task automatic test_back_to_back();
        int c0;
        begin_test();
        load_image(8, 64, 1'b0);
        compute_expected(8, 8, 8, 2, 2);
        compute_expected(4, 8, 8, 4, 4);
        c0 = done_cnt;
        run_pool(8, 8, 8, 2, 2);
        run_pool(4, 8, 8, 4, 4);     // start in the cycle after done
        repeat (3) @(posedge clk);
        check_val("back_to_back", 2, done_cnt - c0);
        check_results("back_to_back", 32);
        end_test("back_to_back");
    endtask

    initial begin
        start       = 1'b0;
        data_ch     = 8'd4;
        data_wid    = 16'd8;
        data_hei    = 16'd8;
        pool_horiz  = 4'd2;
        pool_vert   = 4'd2;
        load_en     = 1'b0;
        load_bank   = '0;
        load_addr   = '0;
        load_data   = '0;
        res_rd_en   = 1'b0;
        res_rd_bank = '0;
        res_rd_addr = '0;
        do @(negedge clk); while (rst);
        test_reset_state();
        test_single_block();
        test_extra_block();
        test_rect_windows();
        test_back_to_back();
        repeat (2) @(posedge clk);
        asrt_fails = dut.u_ctrl.u_props.fail_cnt;
        $display("summary: %0d tests, %0d checks, %0d mismatches, %0d assertion failures",
                 n_tests, n_checks, n_err, asrt_fails);
        if (n_err == 0 && asrt_fails == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+include
design/pool_cfg_pkg.sv
design/pool_data_pkg.sv
design/pool_ctrl.sv
design/feature_buffer.sv
design/pool_lane.sv
design/result_buffer.sv
design/pool_top.sv
tb/pool_clk_gen.sv
tb/pool_props.sv
tb/pool_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= pool_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
